/* logic/datapath_pkg.sv */
package datapath_pkg;

	////////////////////////////////////////
	// Widths fixed by the instruction format
	////////////////////////////////////////

	localparam int data_w = 16;
	localparam int reg_addr_w = 4;

	// Codes 9 to 15 are unused and dropped by the decoder
	typedef enum logic [3:0] {
		op_add  = 4'd0,
		op_sub  = 4'd1,
		op_and  = 4'd2,
		op_or   = 4'd3,
		op_xor  = 4'd4,
		op_shl  = 4'd5,
		op_shr  = 4'd6,
		op_addi = 4'd7,
		op_ldi  = 4'd8
	} opcode_t;

	////////////////////////////////////////
	// Instruction word, two views
	////////////////////////////////////////

	// Register form, rd = rs1 op rs2
	typedef struct packed {
		opcode_t opcode;
		logic [reg_addr_w-1:0] rd;
		logic [reg_addr_w-1:0] rs1;
		logic [reg_addr_w-1:0] rs2;
	} instr_r_t;

	// Immediate form, 8-bit constant in the low byte
	typedef struct packed {
		opcode_t opcode;
		logic [reg_addr_w-1:0] rd;
		logic [7:0] imm8;
	} instr_i_t;

	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_word_u;

endpackage

/* logic/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
	input  logic clk,
	input  logic reset,
	input  logic instr_valid,
	input  logic [datapath_pkg::data_w-1:0] instr,
	output logic dec_valid,
	output datapath_pkg::opcode_t dec_opcode,
	output logic [datapath_pkg::reg_addr_w-1:0] dec_rd,
	output logic [datapath_pkg::reg_addr_w-1:0] rs_a,
	output logic [datapath_pkg::reg_addr_w-1:0] rs_b,
	output logic [datapath_pkg::data_w-1:0] dec_imm
);
	import datapath_pkg::*;

	instr_word_u word;
	logic legal;
	logic imm_form;
	logic [reg_addr_w-1:0] next_rs_a;
	logic [data_w-1:0] next_imm;

	assign word = instr;

	// Opcode field sits at the same place in both views
	always_comb begin
		legal = 1'b0;
		imm_form = 1'b0;
		next_imm = '0;
		case (word.r.opcode)
			op_add, op_sub, op_and, op_or, op_xor, op_shl, op_shr: begin
				legal = 1'b1;
			end
			op_addi: begin
				legal = 1'b1;
				imm_form = 1'b1;
				next_imm = {{(data_w-8){word.i.imm8[7]}}, word.i.imm8};
			end
			op_ldi: begin
				legal = 1'b1;
				imm_form = 1'b1;
				next_imm = {{(data_w-8){1'b0}}, word.i.imm8};
			end
			default: legal = 1'b0;
		endcase
		// addi reads its own destination through port a
		next_rs_a = imm_form ? word.i.rd : word.r.rs1;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= instr_valid && legal;
		end
	end

	always_ff @(posedge clk) begin
		dec_opcode <= word.r.opcode;
		dec_rd <= word.r.rd;
		rs_a <= next_rs_a;
		rs_b <= word.r.rs2;
		dec_imm <= next_imm;
	end

	// Raw code above op_ldi must never start a pipeline slot
	assert property (@(posedge clk) disable iff (reset)
		(instr_valid && (instr[data_w-1 -: 4] > 4'(op_ldi))) |=> !dec_valid)
		else $error("illegal opcode %h reached dec_valid", $past(instr[data_w-1 -: 4]));

endmodule

/* logic/register_file.sv */
`timescale 1ns/1ps

module register_file (
	input  logic clk,
	input  logic reset,
	input  logic [datapath_pkg::reg_addr_w-1:0] rs_a,
	input  logic [datapath_pkg::reg_addr_w-1:0] rs_b,
	input  logic wr_en,
	input  logic [datapath_pkg::reg_addr_w-1:0] wr_addr,
	input  logic [datapath_pkg::data_w-1:0] wr_data,
	input  logic in_valid,
	input  datapath_pkg::opcode_t in_opcode,
	input  logic [datapath_pkg::reg_addr_w-1:0] in_rd,
	input  logic [datapath_pkg::data_w-1:0] in_imm,
	output logic [datapath_pkg::data_w-1:0] rd_data_a,
	output logic [datapath_pkg::data_w-1:0] rd_data_b,
	output logic out_valid,
	output datapath_pkg::opcode_t out_opcode,
	output logic [datapath_pkg::reg_addr_w-1:0] out_rd,
	output logic [datapath_pkg::data_w-1:0] out_imm
);
	import datapath_pkg::*;

	localparam int num_regs = 1 << reg_addr_w;

	logic [data_w-1:0] regs [num_regs];

	////////////////////////////////////////
	// Storage
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Write-first, a same-edge write wins over the stored value
	always_ff @(posedge clk) begin
		rd_data_a <= (wr_en && (wr_addr == rs_a)) ? wr_data : regs[rs_a];
		rd_data_b <= (wr_en && (wr_addr == rs_b)) ? wr_data : regs[rs_b];
	end

	////////////////////////////////////////
	// Control delayed alongside read data
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		out_opcode <= in_opcode;
		out_rd <= in_rd;
		out_imm <= in_imm;
	end

	assert property (@(posedge clk) disable iff (reset) wr_en |-> !$isunknown(wr_addr))
		else $error("write enable with unknown address %b", wr_addr);

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps

module alu (
	input  datapath_pkg::opcode_t op,
	input  logic [datapath_pkg::data_w-1:0] a,
	input  logic [datapath_pkg::data_w-1:0] b,
	input  logic [datapath_pkg::data_w-1:0] imm,
	output logic [datapath_pkg::data_w-1:0] y
);
	import datapath_pkg::*;

	// Shift amount is the low nibble of operand b
	logic [3:0] shamt;

	assign shamt = b[3:0];

	// Sums and differences drop the carry, so they wrap
	always_comb begin
		case (op)
			op_add: begin
				y = a + b;
			end
			op_sub: begin
				y = a - b;
			end
			op_and: begin
				y = a & b;
			end
			op_or: begin
				y = a | b;
			end
			op_xor: begin
				y = a ^ b;
			end
			op_shl: begin
				y = a << shamt;
			end
			op_shr: begin
				// Logical, zeros fill from the top
				y = a >> shamt;
			end
			op_addi: begin
				// a holds rd here, imm is already sign extended
				y = a + imm;
			end
			op_ldi: begin
				y = imm;
			end
			default: begin
				y = '0;
			end
		endcase
	end

endmodule

/* logic/writeback_stage.sv */
`timescale 1ns/1ps

module writeback_stage (
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	input  logic [datapath_pkg::reg_addr_w-1:0] in_dest,
	input  logic [datapath_pkg::data_w-1:0] in_data,
	output logic wr_en,
	output logic [datapath_pkg::reg_addr_w-1:0] wr_addr,
	output logic [datapath_pkg::data_w-1:0] wr_data,
	output logic result_valid,
	output logic [datapath_pkg::reg_addr_w-1:0] result_dest,
	output logic [datapath_pkg::data_w-1:0] result_data,
	output logic result_zero
);

	// Register write lands on the same edge as the result register,
	// so a reader one slot behind sees it through the write-first path
	assign wr_en = in_valid;
	assign wr_addr = in_dest;
	assign wr_data = in_data;

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		result_dest <= in_dest;
		result_data <= in_data;
	end

	assign result_zero = (result_data == '0);

	// No unknown bits may be stored back into the register file
	assert property (@(posedge clk) disable iff (reset) wr_en |-> !$isunknown(wr_data))
		else $error("register write with unknown data %h", wr_data);

endmodule

/* logic/datapath_top.sv */
`timescale 1ns/1ps

module datapath_top (
	input  logic clk,
	input  logic reset,
	input  logic instr_valid,
	input  logic [datapath_pkg::data_w-1:0] instr,
	output logic result_valid,
	output logic [datapath_pkg::reg_addr_w-1:0] result_dest,
	output logic [datapath_pkg::data_w-1:0] result_data,
	output logic result_zero
);
	import datapath_pkg::*;

	// Stage one, decoder outputs
	logic dec_valid;
	opcode_t dec_opcode;
	logic [reg_addr_w-1:0] dec_rd;
	logic [reg_addr_w-1:0] rs_a;
	logic [reg_addr_w-1:0] rs_b;
	logic [data_w-1:0] dec_imm;

	// Stage two, read data and delayed control
	logic [data_w-1:0] rd_data_a;
	logic [data_w-1:0] rd_data_b;
	logic alu_valid;
	opcode_t alu_opcode;
	logic [reg_addr_w-1:0] alu_dest;
	logic [data_w-1:0] alu_imm;
	logic [data_w-1:0] alu_result;

	// Write port back into the register file
	logic wr_en;
	logic [reg_addr_w-1:0] wr_addr;
	logic [data_w-1:0] wr_data;

	instr_decoder u_decoder (
		.clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
		.dec_valid(dec_valid), .dec_opcode(dec_opcode), .dec_rd(dec_rd),
		.rs_a(rs_a), .rs_b(rs_b), .dec_imm(dec_imm)
	);

	register_file u_regs (
		.clk(clk), .reset(reset), .rs_a(rs_a), .rs_b(rs_b),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.in_valid(dec_valid), .in_opcode(dec_opcode), .in_rd(dec_rd), .in_imm(dec_imm),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
		.out_valid(alu_valid), .out_opcode(alu_opcode), .out_rd(alu_dest), .out_imm(alu_imm)
	);

	alu u_alu (.op(alu_opcode), .a(rd_data_a), .b(rd_data_b), .imm(alu_imm), .y(alu_result));

	writeback_stage u_writeback (
		.clk(clk), .reset(reset), .in_valid(alu_valid), .in_dest(alu_dest), .in_data(alu_result),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.result_valid(result_valid), .result_dest(result_dest),
		.result_data(result_data), .result_zero(result_zero)
	);

endmodule

/* testbench/result_checker.sv */
`timescale 1ns/1ps

module result_checker (
	input  logic clk,
	input  logic reset,
	input  logic instr_valid,
	input  int exp_id,
	input  logic exp_has,
	input  logic [3:0] exp_dest,
	input  logic [15:0] exp_data,
	input  logic result_valid,
	input  logic [3:0] result_dest,
	input  logic [15:0] result_data,
	input  logic result_zero,
	output int tests_done,
	output int error_count,
	output int pending
);

	// Instruction strobe to result strobe, in cycles
	localparam int latency = 3;

	int cycle = 0;
	logic strobe_taken;

	// One entry per issued instruction, oldest first
	int q_id[$];
	int q_issue[$];
	logic q_has[$];
	logic [3:0] q_dest[$];
	logic [15:0] q_data[$];

	task automatic retire_head();
		void'(q_id.pop_front());
		void'(q_issue.pop_front());
		void'(q_has.pop_front());
		void'(q_dest.pop_front());
		void'(q_data.pop_front());
		tests_done++;
	endtask

	// Slot of a dropped instruction must pass without a strobe
	task automatic retire_dropped();
		if (result_valid && (q_issue[0] + latency == cycle)) begin
			$display("Test %0d: dropped instruction still produced a result strobe", q_id[0]);
			error_count++;
			strobe_taken = 1'b1;
		end else begin
			$display("Test %0d ok: dropped, no result", q_id[0]);
		end
		retire_head();
	endtask

	task automatic compare_result();
		int lat;
		int errs_before;
		lat = cycle - q_issue[0];
		errs_before = error_count;
		if (lat != latency) begin
			$display("Test %0d: result came %0d cycles after the instruction, not %0d",
				q_id[0], lat, latency);
			error_count++;
		end
		if (result_dest !== q_dest[0]) begin
			$display("Fail test %0d: result_dest got %h expected %h", q_id[0], result_dest, q_dest[0]);
			error_count++;
		end
		if (result_data !== q_data[0]) begin
			$display("Fail test %0d: result_data got %h expected %h", q_id[0], result_data, q_data[0]);
			error_count++;
		end
		// Zero flag follows from the expected value alone
		if (result_zero !== (q_data[0] == 16'h0)) begin
			$display("Fail test %0d: result_zero got %h expected %h",
				q_id[0], result_zero, (q_data[0] == 16'h0));
			error_count++;
		end
		if (error_count == errs_before) begin
			$display("Test %0d ok: r%0d = %h", q_id[0], q_dest[0], q_data[0]);
		end
		retire_head();
	endtask

	////////////////////////////////////////
	// Sampling on the rising edge
	////////////////////////////////////////

	always @(posedge clk) begin
		cycle = cycle + 1;
		strobe_taken = 1'b0;
		if (reset) begin
			tests_done = 0;
			error_count = 0;
		end else begin
			if (instr_valid) begin
				q_id.push_back(exp_id);
				q_issue.push_back(cycle);
				q_has.push_back(exp_has);
				q_dest.push_back(exp_dest);
				q_data.push_back(exp_data);
			end
			while (q_id.size() > 0 && !q_has[0] && (q_issue[0] + latency <= cycle)) begin
				retire_dropped();
			end
			if (result_valid && !strobe_taken) begin
				if (q_id.size() == 0 || !q_has[0]) begin
					$display("Result strobe for r%0d arrived with no result expected", result_dest);
					error_count++;
				end else begin
					compare_result();
				end
			end
			// Late or missing strobe
			if (q_id.size() > 0 && q_has[0] && (q_issue[0] + latency < cycle)) begin
				$display("Test %0d: no result strobe %0d cycles after the instruction",
					q_id[0], latency);
				error_count++;
				retire_head();
			end
		end
		pending = q_id.size();
	end

endmodule

/* testbench/tb_datapath.sv */
`timescale 1ns/1ps

module tb_datapath;
	import datapath_pkg::*;

	localparam int max_cases = 64;
	localparam int case_cols = 5;
	localparam int latency = 3;
	localparam int reset_cycles = 2;

	logic clk;
	logic reset;
	logic instr_valid;
	logic [15:0] instr;
	logic result_valid;
	logic [3:0] result_dest;
	logic [15:0] result_data;
	logic result_zero;

	// Expectation travelling with each instruction
	int exp_id;
	logic exp_has;
	logic [3:0] exp_dest;
	logic [15:0] exp_data;

	int tests_done;
	int error_count;
	int pending;

	logic [15:0] case_mem [0:max_cases*case_cols-1];
	int num_cases;
	int num_illegal;
	int seed;
	int timeout_limit = 1000;
	int cycle_count = 0;

	datapath_top dut (
		.clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
		.result_valid(result_valid), .result_dest(result_dest),
		.result_data(result_data), .result_zero(result_zero)
	);

	result_checker u_checker (
		.clk(clk), .reset(reset), .instr_valid(instr_valid),
		.exp_id(exp_id), .exp_has(exp_has), .exp_dest(exp_dest), .exp_data(exp_data),
		.result_valid(result_valid), .result_dest(result_dest),
		.result_data(result_data), .result_zero(result_zero),
		.tests_done(tests_done), .error_count(error_count), .pending(pending)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	// Cases run until the end marker in the gap column
	task automatic load_cases();
		int base;
		$readmemh("testbench/datapath_cases.txt", case_mem);
		num_cases = 0;
		num_illegal = 0;
		base = 0;
		while (num_cases < max_cases && case_mem[base] != 16'hf) begin
			if (case_mem[base+1][15:12] > 4'(op_ldi)) begin
				num_illegal++;
			end
			num_cases++;
			base += case_cols;
		end
	endtask

	task automatic issue_case(input int idx);
		int base;
		int idle;
		base = idx * case_cols;
		if (case_mem[base] != 16'h0) begin
			idle = $unsigned($random(seed)) % 3;
			repeat (idle) begin
				@(posedge clk);
				instr_valid <= 1'b0;
			end
		end
		@(posedge clk);
		instr_valid <= 1'b1;
		instr <= case_mem[base+1];
		exp_id <= idx + 1;
		exp_has <= case_mem[base+2][0];
		exp_dest <= case_mem[base+3][3:0];
		exp_data <= case_mem[base+4];
	endtask

	// Falling edge sampling keeps clear of checker updates
	task automatic wait_for_drain();
		do begin
			@(negedge clk);
		end while (pending != 0);
		repeat (4) @(negedge clk);
	endtask

	initial begin
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		exp_id = 0;
		exp_has = 1'b0;
		exp_dest = '0;
		exp_data = '0;
		seed = 52;
		load_cases();
		timeout_limit = num_cases * 3 + latency + reset_cycles + 20;
		$display("Running %0d cases, %0d with illegal opcodes", num_cases, num_illegal);
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < num_cases; i++) begin
			issue_case(i);
		end
		@(posedge clk);
		instr_valid <= 1'b0;
		wait_for_drain();
		$display("%0d of %0d tests run, %0d errors", tests_done, num_cases, error_count);
		if (error_count == 0 && tests_done == num_cases && num_cases > 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit) begin
			$display("Timeout after %0d cycles with %0d results still expected",
				cycle_count, pending);
			$display("%0d of %0d tests run, %0d errors", tests_done, num_cases, error_count);
			$display("Regression failed");
			$finish;
		end
	end

endmodule

/* all.f */
logic/datapath_pkg.sv
logic/instr_decoder.sv
logic/register_file.sv
logic/alu.sv
logic/writeback_stage.sv
logic/datapath_top.sv
testbench/result_checker.sv
testbench/tb_datapath.sv

/* run.sh */
#!/bin/sh
# Builds the datapath testbench with Verilator and runs the regression
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_datapath -f all.f -o sim_datapath
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_datapath > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# The log decides pass or fail
if grep -q "^Regression passed$" sim.log; then
	exit 0
fi
exit 1

/* testbench/datapath_cases.txt */
// Columns: gap, instruction, result expected (1) or dropped (0), destination, value
// Gap 0 issues right after the previous instruction, 1 allows 0 to 2 idle cycles, f ends the list
1 0100 1 1 0000
1 02ef 1 2 0000
1 8134 1 1 0034
1 82ff 1 2 00ff
1 8305 1 3 0005
1 0412 1 4 0133
1 1512 1 5 ff35
1 2612 1 6 0034
1 3743 1 7 0137
1 4852 1 8 ffca
1 5923 1 9 1fe0
1 6a53 1 a 07f9
1 0b58 1 b feff
1 1c11 1 c 0000
1 5d34 1 d 0028
// Dependent chain, no idle cycles
1 8110 1 1 0010
0 0211 1 2 0020
0 0321 1 3 0030
0 1432 1 4 0010
0 4443 1 4 0020
// Immediate adds, negative and positive
0 73fd 1 3 002d
1 7580 1 5 feb5
1 767f 1 6 00b3
// Illegal opcodes, then reads of the registers they name
1 9612 0 0 0000
0 f6ff 0 0 0000
0 3960 1 9 00b3
1 a100 0 0 0000
0 0a10 1 a 0010
f 0000 0 0 0000
